// ==== source/dcachePkg.sv ====
// Data cache widths, vector types, access size enum and memory size codes
package dcachePkg;

  //////////////////////////////////////////////////////////////////////
  // Address and data widths
  //////////////////////////////////////////////////////////////////////

  // Byte address of the load/store unit
  localparam int ADDR_BITS = 32;

  // One load/store word and its byte count
  localparam int DATA_BITS  = 64;
  localparam int DATA_BYTES = DATA_BITS / 8;

  // Byte offset bits inside one word
  localparam int WORD_BYTE_BITS = 3;

  typedef logic [ADDR_BITS-1:0]  addrT;
  typedef logic [DATA_BITS-1:0]  dataT;
  typedef logic [DATA_BYTES-1:0] byteEnT;

  //////////////////////////////////////////////////////////////////////
  // Access sizes
  //////////////////////////////////////////////////////////////////////

  // Ordered by width, so a compare reads as "size at most"
  typedef enum logic [1:0] {
    LDST_BYTE   = 2'd0,
    LDST_HALF   = 2'd1,
    LDST_WORD   = 2'd2,
    LDST_DOUBLE = 2'd3
  } ldstSizeE;

  // Size field of a store message towards memory
  typedef logic [2:0] memSizeT;

  localparam memSizeT MEM_SIZE_1B = 3'b001;
  localparam memSizeT MEM_SIZE_2B = 3'b010;
  localparam memSizeT MEM_SIZE_4B = 3'b011;
  localparam memSizeT MEM_SIZE_8B = 3'b100;

endpackage

// ==== source/dcacheIfs.sv ====
// Store buffer head interface and line fill interface
`timescale 1ns/1ns

// Oldest store in the buffer, offered to the cache arrays
interface stbHeadIf import dcachePkg::*; #(
  parameter int lineIndexBits = 4,
  parameter int lineWordsLog  = 2
);
  localparam int tagBits = ADDR_BITS - WORD_BYTE_BITS - lineWordsLog - lineIndexBits;

  // Head address split into tag, line index and word in line
  logic [tagBits-1:0]       tag;
  logic [lineIndexBits-1:0] index;
  logic [lineWordsLog-1:0]  offset;
  // Word-aligned store data and its byte enables
  dataT                     data;
  byteEnT                   byteEn;
  // Head leaves the buffer at the next edge
  logic                     retire;

  modport source (output tag, index, offset, data, byteEn, retire);
  modport sink   (input  tag, index, offset, data, byteEn, retire);
endinterface

// Staged line fill from the miss handler
interface lineFillIf import dcachePkg::*; #(
  parameter int lineIndexBits = 4,
  parameter int lineWordsLog  = 2
);
  localparam int tagBits  = ADDR_BITS - WORD_BYTE_BITS - lineWordsLog - lineIndexBits;
  localparam int lineBits = DATA_BITS << lineWordsLog;

  logic                     valid;
  logic [lineIndexBits-1:0] index;
  logic [tagBits-1:0]       tag;
  logic [lineBits-1:0]      line;

  modport source (output valid, index, tag, line);
  modport sink   (input  valid, index, tag, line);
endinterface

// ==== source/storeBuffer.sv ====
// Store alignment, circular store buffer, load forwarding search and head retirement
`timescale 1ns/1ns

module storeBuffer import dcachePkg::*; #(
  parameter int lineIndexBits = 4,
  parameter int lineWordsLog  = 2,
  parameter int stbDepth      = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stEn_i,
  input  addrT     stAddr_i,
  input  ldstSizeE stSize_i,
  input  dataT     stData_i,
  input  addrT     ldAddr_i,
  input  ldstSizeE ldSize_i,
  input  logic     mem2dcStComplete_i,
  input  logic     mem2dcStStall_i,
  output logic     fwdHit_o,
  output logic     fwdPartial_o,
  output dataT     fwdData_o,
  output logic     fwdSizeOk_o,
  output logic     stallStCommit_o,
  output logic     stbEmpty_o,
  output addrT     dc2memStAddr_o,
  output dataT     dc2memStData_o,
  output memSizeT  dc2memStSize_o,
  output logic     dc2memStValid_o,
  stbHeadIf.source head
);

  localparam int ptrBits = (stbDepth > 1) ? $clog2(stbDepth) : 1;
  localparam int offBits = WORD_BYTE_BITS + lineWordsLog;
  localparam int tagBits = ADDR_BITS - offBits - lineIndexBits;

  typedef logic [ptrBits-1:0] stbPtrT;

  // Aligned store and the memory message built from it
  dataT     stAligned;
  byteEnT   stByteEn;
  dataT     stMemData;
  memSizeT  stMemSize;

  // Buffer entries and pointers
  addrT     stbAddr   [stbDepth];
  dataT     stbData   [stbDepth];
  byteEnT   stbByteEn [stbDepth];
  ldstSizeE stbSize   [stbDepth];
  logic [stbDepth-1:0] stbValid;
  stbPtrT   stbHead;
  stbPtrT   stbTail;
  stbPtrT   fwdIdx;
  addrT     headAddr;
  logic     compD1;

  // Wrap a pointer at the buffer depth
  function automatic stbPtrT nextPtr(input stbPtrT ptr);
    return (ptr == stbPtrT'(stbDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Store alignment
  //////////////////////////////////////////////////////////////////////

  // Cache copy is shifted into word position, memory copy is replicated
  always_comb
  begin
    case (stSize_i)
      LDST_BYTE:
      begin
        stAligned = stData_i << {stAddr_i[2:0], 3'b000};
        stByteEn  = 8'h01 << stAddr_i[2:0];
        stMemData = {8{stData_i[7:0]}};
        stMemSize = MEM_SIZE_1B;
      end
      LDST_HALF:
      begin
        stAligned = stData_i << {stAddr_i[2:1], 4'h0};
        stByteEn  = 8'h03 << {stAddr_i[2:1], 1'b0};
        stMemData = {4{stData_i[15:0]}};
        stMemSize = MEM_SIZE_2B;
      end
      LDST_WORD:
      begin
        stAligned = stData_i << {stAddr_i[2], 5'h00};
        stByteEn  = 8'h0f << {stAddr_i[2], 2'b00};
        stMemData = {2{stData_i[31:0]}};
        stMemSize = MEM_SIZE_4B;
      end
      default:
      begin
        stAligned = stData_i;
        stByteEn  = 8'hff;
        stMemData = stData_i;
        stMemSize = MEM_SIZE_8B;
      end
    endcase
  end

  // Store message leaves one cycle after commit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      dc2memStValid_o <= 1'b0;
      compD1          <= 1'b0;
    end
    else
    begin
      dc2memStValid_o <= stEn_i;
      compD1          <= mem2dcStComplete_i;
    end
  end

  always_ff @(posedge clk)
  begin
    dc2memStAddr_o <= stAddr_i;
    dc2memStData_o <= stMemData;
    dc2memStSize_o <= stMemSize;
  end

  //////////////////////////////////////////////////////////////////////
  // Circular buffer
  //////////////////////////////////////////////////////////////////////

  // Entry payload, written at the tail
  always_ff @(posedge clk)
  begin
    if (stEn_i)
    begin
      stbAddr[stbTail]   <= stAddr_i;
      stbData[stbTail]   <= stAligned;
      stbByteEn[stbTail] <= stByteEn;
      stbSize[stbTail]   <= stSize_i;
    end
  end

  // Tail grows on commit, head drops on registered completion
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      stbHead  <= '0;
      stbTail  <= '0;
      stbValid <= '0;
    end
    else
    begin
      if (stEn_i)
      begin
        stbValid[stbTail] <= 1'b1;
        stbTail           <= nextPtr(stbTail);
      end
      if (compD1)
      begin
        stbValid[stbHead] <= 1'b0;
        stbHead           <= nextPtr(stbHead);
      end
    end
  end

  assign stbEmpty_o      = ~|stbValid;
  assign stallStCommit_o = mem2dcStStall_i | (&stbValid);

  // Walk from oldest to youngest so the last same-word match wins
  always_comb
  begin : fwdSearch
    stbPtrT idx;
    logic   wordMatch;
    logic   byteMatch;
    logic   sizeOk;
    fwdHit_o     = 1'b0;
    fwdPartial_o = 1'b0;
    fwdSizeOk_o  = 1'b0;
    fwdIdx       = '0;
    for (int i = 0; i < stbDepth; i++)
    begin
      idx       = stbPtrT'((int'(stbHead) + i) % stbDepth);
      wordMatch = stbValid[idx] & (stbAddr[idx][ADDR_BITS-1:WORD_BYTE_BITS] ==
                                   ldAddr_i[ADDR_BITS-1:WORD_BYTE_BITS]);
      byteMatch = stbAddr[idx][WORD_BYTE_BITS-1:0] == ldAddr_i[WORD_BYTE_BITS-1:0];
      sizeOk    = ldSize_i <= stbSize[idx];
      if (wordMatch & byteMatch)
      begin
        fwdHit_o    = 1'b1;
        fwdSizeOk_o = sizeOk;
        fwdIdx      = idx;
      end
      // Other offset or too narrow a store
      if (wordMatch & ~(byteMatch & sizeOk))
        fwdPartial_o = 1'b1;
    end
  end

  assign fwdData_o = stbData[fwdIdx];

  // Head entry towards the cache arrays
  assign headAddr    = stbAddr[stbHead];
  assign head.tag    = headAddr[ADDR_BITS-1 -: tagBits];
  assign head.index  = headAddr[offBits +: lineIndexBits];
  assign head.offset = headAddr[WORD_BYTE_BITS +: lineWordsLog];
  assign head.data   = stbData[stbHead];
  assign head.byteEn = stbByteEn[stbHead];
  assign head.retire = compD1;

endmodule

// ==== source/missHandler.sv ====
// Miss request pulse, single miss status register and staged line fill
`timescale 1ns/1ns

module missHandler import dcachePkg::*; #(
  parameter int  lineIndexBits = 4,
  parameter int  lineWordsLog  = 2,
  localparam int offBits       = WORD_BYTE_BITS + lineWordsLog,
  localparam int tagBits       = ADDR_BITS - offBits - lineIndexBits,
  localparam int lineBits      = DATA_BITS << lineWordsLog
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         ldEn_i,
  input  addrT                         ldAddr_i,
  input  logic                         ldMiss_i,
  input  logic [tagBits-1:0]           mem2dcLdTag_i,
  input  logic [lineIndexBits-1:0]     mem2dcLdIndex_i,
  input  logic [lineBits-1:0]          mem2dcLdData_i,
  input  logic                         mem2dcLdValid_i,
  output logic [ADDR_BITS-offBits-1:0] dc2memLdAddr_o,
  output logic                         dc2memLdValid_o,
  lineFillIf.source                    fill
);

  // Registered miss and its line address
  logic                         missD1;
  logic [ADDR_BITS-offBits-1:0] missLine;
  // Miss status register
  logic                         mshrValid;
  logic [tagBits-1:0]           mshrTag;
  logic [lineIndexBits-1:0]     mshrIndex;
  logic                         fillSameLd;
  logic                         fillOther;
  logic                         respMatch;

  // Load line is already being written this cycle
  assign fillSameLd = fill.valid & ({fill.tag, fill.index} == ldAddr_i[ADDR_BITS-1:offBits]);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      missD1 <= 1'b0;
    else
      missD1 <= ldMiss_i & ~fillSameLd;
  end

  always_ff @(posedge clk)
  begin
    if (ldEn_i)
      missLine <= ldAddr_i[ADDR_BITS-1:offBits];
  end

  //////////////////////////////////////////////////////////////////////
  // Request and miss status register
  //////////////////////////////////////////////////////////////////////

  // Register frees this cycle with some other line
  assign fillOther = fill.valid & ({fill.tag, fill.index} != missLine);

  // One pulse per miss, busy register means replay without request
  assign dc2memLdValid_o = missD1 & (~mshrValid | fillOther);
  assign dc2memLdAddr_o  = missLine;

  // Only the outstanding line is taken, never while one is staged
  assign respMatch = mem2dcLdValid_i & mshrValid & ~fill.valid &
                     (mem2dcLdTag_i == mshrTag) & (mem2dcLdIndex_i == mshrIndex);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshrValid  <= 1'b0;
      fill.valid <= 1'b0;
    end
    else
    begin
      fill.valid <= respMatch;
      if (dc2memLdValid_o)
        mshrValid <= 1'b1;
      else if (fill.valid)
        mshrValid <= 1'b0;
    end
  end

  // Line staged for one cycle before the array write
  always_ff @(posedge clk)
  begin
    if (dc2memLdValid_o)
      {mshrTag, mshrIndex} <= missLine;
    if (respMatch)
    begin
      fill.tag   <= mshrTag;
      fill.index <= mshrIndex;
      fill.line  <= mem2dcLdData_i;
    end
  end

endmodule

// ==== source/cacheArrays.sv ====
// Data, tag and valid arrays with store merge, fill write and flush
`timescale 1ns/1ns

module cacheArrays import dcachePkg::*; #(
  parameter int lineIndexBits = 4,
  parameter int lineWordsLog  = 2
) (
  input  logic   clk,
  input  logic   reset,
  input  addrT   ldAddr_i,
  input  logic   dcFlush_i,
  output dataT   lineWord_o,
  output logic   lineHit_o,
  output logic   dcFlushDone_o,
  stbHeadIf.sink head,
  lineFillIf.sink fill
);

  localparam int offBits  = WORD_BYTE_BITS + lineWordsLog;
  localparam int tagBits  = ADDR_BITS - offBits - lineIndexBits;
  localparam int numLines = 1 << lineIndexBits;
  localparam int lineBits = DATA_BITS << lineWordsLog;

  typedef logic [lineBits-1:0] lineT;
  typedef logic [tagBits-1:0]  tagT;

  lineT                     dataArr [numLines];
  tagT                      tagArr  [numLines];
  logic [numLines-1:0]      validArr;
  logic [lineIndexBits-1:0] ldIndex;
  logic [lineWordsLog-1:0]  ldWord;
  tagT                      ldTag;
  lineT                     ldLine;
  lineT                     storeLine;
  logic                     storeWr;

  // Load read port
  assign ldTag      = ldAddr_i[ADDR_BITS-1 -: tagBits];
  assign ldIndex    = ldAddr_i[offBits +: lineIndexBits];
  assign ldWord     = ldAddr_i[WORD_BYTE_BITS +: lineWordsLog];
  assign ldLine     = dataArr[ldIndex];
  assign lineWord_o = ldLine[ldWord*DATA_BITS +: DATA_BITS];
  assign lineHit_o  = validArr[ldIndex] & (tagArr[ldIndex] == ldTag);

  // No allocate on write, a fill to the same index wins
  assign storeWr = head.retire & validArr[head.index] & (tagArr[head.index] == head.tag) &
                   ~(fill.valid & (fill.index == head.index));

  // Retiring store merged into its line byte by byte
  always_comb
  begin
    storeLine = dataArr[head.index];
    for (int b = 0; b < DATA_BYTES; b++)
    begin
      if (head.byteEn[b])
        storeLine[(head.offset*DATA_BYTES + b)*8 +: 8] = head.data[b*8 +: 8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill.valid)
    begin
      dataArr[fill.index] <= fill.line;
      tagArr[fill.index]  <= fill.tag;
    end
    if (storeWr)
      dataArr[head.index] <= storeLine;
  end

  // Flush drops every line and answers one cycle later
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      validArr      <= '0;
      dcFlushDone_o <= 1'b0;
    end
    else
    begin
      dcFlushDone_o <= dcFlush_i;
      if (dcFlush_i)
        validArr <= '0;
      else if (fill.valid)
        validArr[fill.index] <= 1'b1;
    end
  end

endmodule

// ==== source/loadPath.sv ====
// Load hit decision, word select and load alignment with sign extension
`timescale 1ns/1ns

module loadPath import dcachePkg::*; (
  input  logic     ldEn_i,
  input  addrT     ldAddr_i,
  input  ldstSizeE ldSize_i,
  input  logic     ldSign_i,
  input  logic     fwdHit_i,
  input  logic     fwdPartial_i,
  input  logic     fwdSizeOk_i,
  input  dataT     fwdData_i,
  input  dataT     lineWord_i,
  input  logic     lineHit_i,
  output dataT     ldData_o,
  output logic     ldHit_o,
  output logic     ldMiss_o
);

  logic hit;
  dataT srcWord;
  dataT shifted;

  // Partial overlap with a pending store must wait for its retirement
  always_comb
  begin
    if (fwdPartial_i)
      hit = 1'b0;
    else if (fwdHit_i)
      hit = fwdSizeOk_i;
    else
      hit = lineHit_i;
  end

  assign ldHit_o  = ldEn_i & hit;
  assign ldMiss_o = ldEn_i & ~hit;

  // Store buffer holds the newer value
  assign srcWord = fwdHit_i ? fwdData_i : lineWord_i;
  assign shifted = srcWord >> {ldAddr_i[WORD_BYTE_BITS-1:0], 3'b000};

  // Mask to size, sign extend on request
  always_comb
  begin
    case (ldSize_i)
      LDST_BYTE:
        ldData_o = {{56{ldSign_i & shifted[7]}}, shifted[7:0]};
      LDST_HALF:
        ldData_o = {{48{ldSign_i & shifted[15]}}, shifted[15:0]};
      LDST_WORD:
        ldData_o = {{32{ldSign_i & shifted[31]}}, shifted[31:0]};
      default:
        ldData_o = shifted;
    endcase
  end

endmodule

// ==== source/dcacheTop.sv ====
// Data cache controller top level with plain ports and internal wiring
`timescale 1ns/1ns

module dcacheTop import dcachePkg::*; #(
  parameter int  lineIndexBits = 4,
  parameter int  lineWordsLog  = 2,
  parameter int  stbDepth      = 4,
  localparam int offBits       = WORD_BYTE_BITS + lineWordsLog,
  localparam int tagBits       = ADDR_BITS - offBits - lineIndexBits,
  localparam int lineBits      = DATA_BITS << lineWordsLog
) (
  input  logic                         clk,
  input  logic                         reset,
  // Loads from the load/store unit
  input  logic                         ldEn_i,
  input  addrT                         ldAddr_i,
  input  ldstSizeE                     ldSize_i,
  input  logic                         ldSign_i,
  output dataT                         ldData_o,
  output logic                         ldHit_o,
  output logic                         ldMiss_o,
  // Committed stores
  input  logic                         stEn_i,
  input  addrT                         stAddr_i,
  input  ldstSizeE                     stSize_i,
  input  dataT                         stData_i,
  output logic                         stallStCommit_o,
  output logic                         stbEmpty_o,
  // Line requests and fill responses
  output logic [ADDR_BITS-offBits-1:0] dc2memLdAddr_o,
  output logic                         dc2memLdValid_o,
  input  logic [tagBits-1:0]           mem2dcLdTag_i,
  input  logic [lineIndexBits-1:0]     mem2dcLdIndex_i,
  input  logic [lineBits-1:0]          mem2dcLdData_i,
  input  logic                         mem2dcLdValid_i,
  // Write-through stores
  output addrT                         dc2memStAddr_o,
  output dataT                         dc2memStData_o,
  output memSizeT                      dc2memStSize_o,
  output logic                         dc2memStValid_o,
  input  logic                         mem2dcStComplete_i,
  input  logic                         mem2dcStStall_i,
  // Whole-cache flush
  input  logic                         dcFlush_i,
  output logic                         dcFlushDone_o
);

  // Forwarding result and cache read result
  logic fwdHit;
  logic fwdPartial;
  logic fwdSizeOk;
  dataT fwdData;
  dataT lineWord;
  logic lineHit;

  stbHeadIf  #(.lineIndexBits(lineIndexBits), .lineWordsLog(lineWordsLog)) stbHead ();
  lineFillIf #(.lineIndexBits(lineIndexBits), .lineWordsLog(lineWordsLog)) lineFill ();

  storeBuffer #(
    .lineIndexBits(lineIndexBits),
    .lineWordsLog(lineWordsLog),
    .stbDepth(stbDepth)
  ) stbInst (
    .clk, .reset,
    .stEn_i, .stAddr_i, .stSize_i, .stData_i,
    .ldAddr_i, .ldSize_i,
    .mem2dcStComplete_i, .mem2dcStStall_i,
    .fwdHit_o(fwdHit), .fwdPartial_o(fwdPartial),
    .fwdData_o(fwdData), .fwdSizeOk_o(fwdSizeOk),
    .stallStCommit_o, .stbEmpty_o,
    .dc2memStAddr_o, .dc2memStData_o, .dc2memStSize_o, .dc2memStValid_o,
    .head(stbHead)
  );

  missHandler #(
    .lineIndexBits(lineIndexBits),
    .lineWordsLog(lineWordsLog)
  ) mshrInst (
    .clk, .reset,
    .ldEn_i, .ldAddr_i, .ldMiss_i(ldMiss_o),
    .mem2dcLdTag_i, .mem2dcLdIndex_i, .mem2dcLdData_i, .mem2dcLdValid_i,
    .dc2memLdAddr_o, .dc2memLdValid_o,
    .fill(lineFill)
  );

  cacheArrays #(
    .lineIndexBits(lineIndexBits),
    .lineWordsLog(lineWordsLog)
  ) arrInst (
    .clk, .reset,
    .ldAddr_i, .dcFlush_i,
    .lineWord_o(lineWord), .lineHit_o(lineHit), .dcFlushDone_o,
    .head(stbHead),
    .fill(lineFill)
  );

  loadPath ldInst (
    .ldEn_i, .ldAddr_i, .ldSize_i, .ldSign_i,
    .fwdHit_i(fwdHit), .fwdPartial_i(fwdPartial), .fwdSizeOk_i(fwdSizeOk),
    .fwdData_i(fwdData), .lineWord_i(lineWord), .lineHit_i(lineHit),
    .ldData_o, .ldHit_o, .ldMiss_o
  );

endmodule

// ==== testbench/dcacheTop_props.sv ====
// Concurrent checks on the data cache top-level handshakes and reset values
`timescale 1ns/1ns

module dcacheTop_props (
  input logic clk,
  input logic reset,
  input logic stEn_i,
  input logic stallStCommit_o,
  input logic dc2memLdValid_o,
  input logic dc2memStValid_o,
  input logic dcFlush_i,
  input logic dcFlushDone_o,
  input logic stbEmpty_o
);

  // Load/store unit holds its stores while stalled
  noStoreWhileStalled: assert property (@(posedge clk) disable iff (reset)
    stallStCommit_o |-> !stEn_i)
    else $error("Store commit while stallStCommit_o is high");

  // One request pulse per miss
  singleCycleLdRequest: assert property (@(posedge clk) disable iff (reset)
    dc2memLdValid_o |=> !dc2memLdValid_o)
    else $error("dc2memLdValid_o high in two consecutive cycles");

  // Done pulse exactly one cycle after the flush
  flushDoneFollows: assert property (@(posedge clk) disable iff (reset)
    dcFlushDone_o == $past(dcFlush_i))
    else $error("dcFlushDone_o does not follow dcFlush_i by one cycle");

  quietDuringReset: assert property (@(posedge clk)
    reset |-> (!dc2memLdValid_o && !dc2memStValid_o && !dcFlushDone_o &&
               !stallStCommit_o && stbEmpty_o))
    else $error("Control outputs active during reset");

endmodule

bind dcacheTop dcacheTop_props propsInst (
  .clk(clk),
  .reset(reset),
  .stEn_i(stEn_i),
  .stallStCommit_o(stallStCommit_o),
  .dc2memLdValid_o(dc2memLdValid_o),
  .dc2memStValid_o(dc2memStValid_o),
  .dcFlush_i(dcFlush_i),
  .dcFlushDone_o(dcFlushDone_o),
  .stbEmpty_o(stbEmpty_o)
);

// ==== testbench/dcacheTb.sv ====
// Data cache testbench with clock, reset, random stimulus, memory model, checks and watchdog
`timescale 1ns/1ns

module dcacheTb import dcachePkg::*; ();

  localparam int lineIndexBits = 4;
  localparam int lineWordsLog  = 2;
  localparam int stbDepth      = 4;
  localparam int clkPeriod     = 4;
  localparam int resetCycles   = 16;
  localparam int numOps        = 2000;

  typedef struct packed {
    addrT     addr;
    dataT     data;
    ldstSizeE size;
    int       due;
  } stRecT;

  logic clk, reset, ldEn_i, ldSign_i, ldHit_o, ldMiss_o, stEn_i;
  logic stallStCommit_o, stbEmpty_o, dc2memLdValid_o, mem2dcLdValid_i;
  logic dc2memStValid_o, mem2dcStComplete_i, mem2dcStStall_i, dcFlush_i, dcFlushDone_o;
  addrT ldAddr_i, stAddr_i, dc2memStAddr_o;
  dataT ldData_o, stData_i, dc2memStData_o;
  ldstSizeE ldSize_i, stSize_i;
  memSizeT dc2memStSize_o;
  logic [26:0] dc2memLdAddr_o;
  logic [22:0] mem2dcLdTag_i;
  logic [3:0] mem2dcLdIndex_i;
  logic [255:0] mem2dcLdData_i;

  // Memory side bytes and architectural bytes
  logic [7:0] memBytes [0:2047];
  logic [7:0] archBytes [0:2047];
  // Lines the cache should hold, as seen by loads
  logic [15:0] lineValid;
  logic [22:0] lineTag [0:15];
  int fillApply, cycle, errors, lastDue, respDue;
  logic [22:0] fillTag;
  logic [3:0] fillIdx;
  logic [26:0] respLine, ldLastLine;
  logic respPending, holdComp, compD1, flushLast, stLast, ldLast, lastMiss;
  // Line written into the arrays at the last edge
  logic wroteNow;
  logic [26:0] wroteLine;
  logic expHit;
  dataT expData;
  stRecT stLastRec;
  // Store committed in the previous cycle, expected on the memory side now
  stRecT stSentRec;
  stRecT pendQ [$];
  stRecT compQ [$];
  integer seed;

  dcacheTop #(
    .lineIndexBits(lineIndexBits),
    .lineWordsLog(lineWordsLog),
    .stbDepth(stbDepth)
  ) DUT (.*);

  always #(clkPeriod / 2) clk = ~clk;

  function automatic int unsigned randBelow(input int unsigned mod);
    return $unsigned($random(seed)) % mod;
  endfunction

  // A few lines and tags, aligned to the access size
  function automatic addrT randAddr(input ldstSizeE sz);
    addrT a;
    a = addrT'($random(seed)) & 32'h0000_067F;
    return a & ~addrT'((1 << sz) - 1);
  endfunction

  function automatic dataT archLoad(input addrT a, input ldstSizeE sz, input logic sgn);
    dataT v;
    int n;
    v = '0;
    n = 1 << sz;
    for (int b = 0; b < n; b++)
      v[8*b +: 8] = archBytes[a[10:0] + b];
    if (sgn && v[8*n-1])
      for (int b = n; b < 8; b++)
        v[8*b +: 8] = 8'hff;
    return v;
  endfunction

  // Memory message copy of a store
  function automatic dataT replicate(input dataT d, input ldstSizeE sz);
    case (sz)
      LDST_BYTE: return {8{d[7:0]}};
      LDST_HALF: return {4{d[15:0]}};
      LDST_WORD: return {2{d[31:0]}};
      default:   return d;
    endcase
  endfunction

  function automatic memSizeT sizeCode(input ldstSizeE sz);
    case (sz)
      LDST_BYTE: return MEM_SIZE_1B;
      LDST_HALF: return MEM_SIZE_2B;
      LDST_WORD: return MEM_SIZE_4B;
      default:   return MEM_SIZE_8B;
    endcase
  endfunction

  task automatic reportMismatch(input string name, input dataT got, input dataT exp);
    errors++;
    $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic reportProblem(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle model update, stimulus and checks
  //////////////////////////////////////////////////////////////////////

  // Buffer occupancy follows commit and the retirement after completion
  task automatic updateAtEdge();
    if (compD1)
      void'(pendQ.pop_front());
    if (stEn_i)
    begin
      pendQ.push_back(stLastRec);
      stSentRec = stLastRec;
    end
    compD1     = mem2dcStComplete_i;
    flushLast  = dcFlush_i;
    stLast     = stEn_i;
    ldLast     = ldEn_i;
    ldLastLine = ldAddr_i[31:5];
    cycle++;
  endtask

  task automatic driveInputs(input int mode);
    stRecT c;
    ldstSizeE sz;
    int pick;
    int base;
    logic sameWord;
    logic partial;
    stEn_i             = 1'b0;
    ldEn_i             = 1'b0;
    dcFlush_i          = 1'b0;
    mem2dcStComplete_i = 1'b0;
    mem2dcLdValid_i    = 1'b0;
    mem2dcStStall_i    = (mode == 2) && (randBelow(8) == 0);
    holdComp           = (mode == 1);
    // Staged fill was on the interface in the previous cycle
    wroteNow  = (fillApply == cycle);
    wroteLine = {fillTag, fillIdx};
    // Flush drops a fill written in the same cycle
    if (flushLast)
    begin
      lineValid = '0;
      if (fillApply == cycle)
        fillApply = -1;
    end
    else if (fillApply == cycle)
    begin
      lineValid[fillIdx] = 1'b1;
      lineTag[fillIdx]   = fillTag;
      fillApply          = -1;
    end
    // Completion first, a due fill response waits a cycle
    if (!holdComp && compQ.size() > 0 && compQ[0].due <= cycle)
    begin
      c = compQ.pop_front();
      for (int b = 0; b < (1 << c.size); b++)
        memBytes[c.addr[10:0] + b] = c.data[8*b +: 8];
      mem2dcStComplete_i = 1'b1;
    end
    else if (respPending && cycle >= respDue)
    begin
      base = {respLine, 5'b00000};
      for (int b = 0; b < 32; b++)
        mem2dcLdData_i[8*b +: 8] = memBytes[base + b];
      mem2dcLdTag_i   = respLine[26:4];
      mem2dcLdIndex_i = respLine[3:0];
      mem2dcLdValid_i = 1'b1;
      fillTag         = respLine[26:4];
      fillIdx         = respLine[3:0];
      fillApply       = cycle + 2;
      respPending     = 1'b0;
    end
    if (mode == 0)
      return;
    if (mode == 2 && randBelow(50) == 0)
      dcFlush_i = 1'b1;
    pick = (mode == 1) ? 0 : randBelow(100);
    if (pick < 35 && !mem2dcStStall_i && pendQ.size() < stbDepth)
    begin
      sz        = ldstSizeE'(randBelow(4));
      stEn_i    = 1'b1;
      stAddr_i  = randAddr(sz);
      stSize_i  = sz;
      stData_i  = {$random(seed), $random(seed)};
      stLastRec = '{addr: stAddr_i, data: stData_i, size: sz, due: 0};
      for (int b = 0; b < (1 << sz); b++)
        archBytes[stAddr_i[10:0] + b] = stData_i[8*b +: 8];
    end
    else if (pick >= 35 && pick < 85)
    begin
      ldEn_i = 1'b1;
      // Replay keeps the address of the missed load
      if (!(lastMiss && randBelow(2) == 0))
      begin
        sz       = ldstSizeE'(randBelow(4));
        ldSize_i = sz;
        ldAddr_i = randAddr(sz);
        ldSign_i = randBelow(2);
      end
      sameWord = 1'b0;
      partial  = 1'b0;
      foreach (pendQ[i])
      begin
        if (pendQ[i].addr[31:3] == ldAddr_i[31:3])
        begin
          sameWord = 1'b1;
          if (pendQ[i].addr[2:0] != ldAddr_i[2:0] || ldSize_i > pendQ[i].size)
            partial = 1'b1;
        end
      end
      expHit  = sameWord ? !partial :
                (lineValid[ldAddr_i[8:5]] && lineTag[ldAddr_i[8:5]] == ldAddr_i[31:9]);
      expData = archLoad(ldAddr_i, ldSize_i, ldSign_i);
    end
  endtask

  task automatic checkOutputs();
    stRecT c;
    logic expReq;
    // Last load missed, nothing outstanding and its line not just written
    expReq = lastMiss && !respPending && fillApply < 0 &&
             !(wroteNow && wroteLine == ldLastLine);
    assert (ldMiss_o == (ldEn_i & ~expHit))
      else reportMismatch("ldMiss_o", ldMiss_o, ldEn_i & ~expHit);
    if (ldEn_i)
    begin
      assert (ldHit_o == expHit) else reportMismatch("ldHit_o", ldHit_o, expHit);
      if (ldHit_o)
        assert (ldData_o == expData) else reportMismatch("ldData_o", ldData_o, expData);
    end
    lastMiss = ldEn_i & ldMiss_o;
    assert (dc2memStValid_o == stLast)
      else reportProblem("Store message on the memory side does not match a commit");
    if (stLast && dc2memStValid_o)
    begin
      assert (dc2memStAddr_o == stSentRec.addr)
        else reportMismatch("dc2memStAddr_o", dc2memStAddr_o, stSentRec.addr);
      assert (dc2memStData_o == replicate(stSentRec.data, stSentRec.size))
        else reportMismatch("dc2memStData_o", dc2memStData_o,
                            replicate(stSentRec.data, stSentRec.size));
      assert (dc2memStSize_o == sizeCode(stSentRec.size))
        else reportMismatch("dc2memStSize_o", dc2memStSize_o, sizeCode(stSentRec.size));
      // In-order completion 2 to 6 cycles out
      c       = stSentRec;
      c.due   = cycle + 2 + randBelow(5);
      c.due   = (c.due > lastDue) ? c.due : lastDue + 1;
      lastDue = c.due;
      compQ.push_back(c);
    end
    assert (stbEmpty_o == (pendQ.size() == 0))
      else reportMismatch("stbEmpty_o", stbEmpty_o, pendQ.size() == 0);
    assert (stallStCommit_o == (mem2dcStStall_i | (pendQ.size() == stbDepth)))
      else reportMismatch("stallStCommit_o", stallStCommit_o,
                          mem2dcStStall_i | (pendQ.size() == stbDepth));
    assert (dcFlushDone_o == flushLast)
      else reportMismatch("dcFlushDone_o", dcFlushDone_o, flushLast);
    if (expReq)
      assert (dc2memLdValid_o)
        else reportProblem("No line request after a miss with the miss register free");
    if (dc2memLdValid_o)
    begin
      assert (ldLast && dc2memLdAddr_o == ldLastLine)
        else reportMismatch("dc2memLdAddr_o", dc2memLdAddr_o, ldLastLine);
      assert (!respPending) else reportProblem("Line request while another is outstanding");
      respPending = 1'b1;
      respLine    = dc2memLdAddr_o;
      respDue     = cycle + 2 + randBelow(5);
    end
  endtask

  task automatic runCycle(input int mode);
    @(posedge clk);
    updateAtEdge();
    #1;
    driveInputs(mode);
    @(negedge clk);
    checkOutputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed = 32'h437c7a79;
    {clk, ldEn_i, ldSign_i, stEn_i, mem2dcLdValid_i, mem2dcStComplete_i} = '0;
    {mem2dcStStall_i, dcFlush_i, ldAddr_i, stAddr_i, stData_i} = '0;
    {mem2dcLdTag_i, mem2dcLdIndex_i, mem2dcLdData_i} = '0;
    ldSize_i = LDST_BYTE;
    stSize_i = LDST_BYTE;
    reset    = 1'b1;
    // Fill pattern mixes low and high address bits
    for (int a = 0; a < 2048; a++)
    begin
      memBytes[a]  = 8'((a * 29) ^ (a >> 7));
      archBytes[a] = memBytes[a];
    end
    {lineValid, respPending, holdComp, compD1, flushLast, stLast, ldLast, lastMiss} = '0;
    wroteNow  = 1'b0;
    fillApply = -1;
    cycle     = 0;
    errors    = 0;
    lastDue   = 0;
    repeat (resetCycles) @(posedge clk);
    #1 reset = 1'b0;
    // Fill the buffer with completions held back
    repeat (stbDepth + 2) runCycle(1);
    repeat (numOps) runCycle(2);
    while (compQ.size() != 0 || pendQ.size() != 0 || respPending || fillApply >= 0)
      runCycle(0);
    runCycle(0);
    assert (stbEmpty_o) else reportProblem("Store buffer not empty after all stores completed");
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #((resetCycles + (numOps + stbDepth) * 20) * clkPeriod);
    $display("Watchdog expired before the test sequence finished");
    $display("Errors: %0d", errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== compile.f ====
source/dcachePkg.sv
source/dcacheIfs.sv
source/storeBuffer.sv
source/missHandler.sv
source/cacheArrays.sv
source/loadPath.sv
source/dcacheTop.sv
testbench/dcacheTop_props.sv
testbench/dcacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb -f compile.f -o dcacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/dcacheSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulator exited with an error"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1
